// ==== verilog/psg_bus_pkg.sv ====
// psg host bus definitions
// types for the capcom two-address write port

package psg_bus_pkg;

  ////////////////////////////////////////////////////////////
  // bus cycle kind, taken straight from the adr pin
  ////////////////////////////////////////////////////////////

  typedef enum logic {
    op_index = 1'b0,  // adr 0 selects a register
    op_data  = 1'b1   // adr 1 writes the selected register
  } bus_op_e;

  ////////////////////////////////////////////////////////////
  // single-cycle register write from the decoder
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic       valid;  // one clk wide
    logic [3:0] idx;    // latched register index
    logic [7:0] data;   // value from din
  } reg_wr_t;

endpackage

// ==== verilog/psg_synth_pkg.sv ====
// psg synthesis definitions
// register map, field widths, decoded register view and channel levels

package psg_synth_pkg;

  ////////////////////////////////////////////////////////////
  // register map, same layout as the ay-3-8910
  ////////////////////////////////////////////////////////////

  localparam logic [3:0] reg_tone_a_lo = 4'd0;
  localparam logic [3:0] reg_tone_a_hi = 4'd1;
  localparam logic [3:0] reg_tone_b_lo = 4'd2;
  localparam logic [3:0] reg_tone_b_hi = 4'd3;
  localparam logic [3:0] reg_tone_c_lo = 4'd4;
  localparam logic [3:0] reg_tone_c_hi = 4'd5;
  localparam logic [3:0] reg_noise_per = 4'd6;
  localparam logic [3:0] reg_mixer     = 4'd7;   // tone dis 2:0, noise dis 5:3
  localparam logic [3:0] reg_amp_a     = 4'd8;
  localparam logic [3:0] reg_amp_b     = 4'd9;
  localparam logic [3:0] reg_amp_c     = 4'd10;
  localparam logic [3:0] reg_env_lo    = 4'd11;
  localparam logic [3:0] reg_env_hi    = 4'd12;
  localparam logic [3:0] reg_env_shape = 4'd13;

  localparam int tone_w        = 12;  // tone period bits
  localparam int noise_w       = 5;   // noise period bits
  localparam int env_w         = 16;  // envelope period bits
  localparam int level_w       = 4;   // channel level bits
  localparam int tone_tick_div = 16;  // clk per tone tick
  localparam int env_tick_div  = 8;   // clk per envelope tick

  // envelope shape bit positions
  localparam int env_hold_bit = 0;
  localparam int env_alt_bit  = 1;
  localparam int env_att_bit  = 2;
  localparam int env_cont_bit = 3;

  ////////////////////////////////////////////////////////////
  // decoded register fields
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [tone_w-1:0]  tone_a;
    logic [tone_w-1:0]  tone_b;
    logic [tone_w-1:0]  tone_c;
    logic [noise_w-1:0] noise_per;
    logic [2:0]         tone_dis;   // bit per channel, a in bit 0
    logic [2:0]         noise_dis;
    logic [level_w:0]   amp_a;      // msb selects envelope
    logic [level_w:0]   amp_b;
    logic [level_w:0]   amp_c;
    logic [env_w-1:0]   env_per;
    logic [3:0]         env_shape;
  } psg_regs_t;

  typedef struct packed {
    logic [level_w-1:0] a;
    logic [level_w-1:0] b;
    logic [level_w-1:0] c;
  } levels_t;

  typedef enum logic [1:0] {
    env_idle,  // after reset, gain parked at 15
    env_ramp,  // stepping
    env_hold   // finished, gain frozen
  } env_phase_e;

endpackage

// ==== verilog/psg_bus_if.sv ====
// psg bus decoder
// capcom style two-location port, adr 0 latches the register index,
// adr 1 turns the cycle into a one-clk register write

`timescale 1ns/100ps

module psg_bus_if (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic [7:0]           din,
  input  logic                 adr,
  input  logic                 wr_n,
  input  logic                 cs_n,
  output psg_bus_pkg::reg_wr_t reg_wr
);

  import psg_bus_pkg::*;

  bus_op_e    op;        // kind of the current cycle
  logic       sample;    // strobes active at this edge
  logic [3:0] idx_q;     // selected register

  assign sample = ~cs_n & ~wr_n;
  assign op     = bus_op_e'(adr);

  ////////////////////////////////////////////////////////////
  // index latch, held until the next select cycle
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      idx_q <= '0;
    end else if (sample && op == op_index) begin
      idx_q <= din[3:0];  // upper nibble ignored
    end
  end

  ////////////////////////////////////////////////////////////
  // write pulse, one clk after the sampled data cycle
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      reg_wr <= '0;
    end else begin
      reg_wr.valid <= sample && op == op_data;  // long strobe repeats the write
      reg_wr.idx   <= idx_q;
      reg_wr.data  <= din;
    end
  end

endmodule

// ==== verilog/psg_reg_file.sv ====
// psg register file
// sixteen 8-bit registers, unpacked into the decoded field view;
// a shape write also restarts the envelope

`timescale 1ns/100ps

module psg_reg_file (
  input  logic                     clk,
  input  logic                     reset_n,
  input  psg_bus_pkg::reg_wr_t     reg_wr,
  output psg_synth_pkg::psg_regs_t regs,
  output logic                     env_restart
);

  import psg_synth_pkg::*;

  localparam int hi_w = tone_w - 8;  // tone bits kept in the hi register

  logic [7:0] mem [16];

  ////////////////////////////////////////////////////////////
  // storage and restart pulse
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < 16; i++) begin
        mem[i] <= '0;  // chip powers up silent
      end
      env_restart <= 1'b0;
    end else begin
      if (reg_wr.valid) begin
        mem[reg_wr.idx] <= reg_wr.data;
      end
      // lines up with the new shape value
      env_restart <= reg_wr.valid && reg_wr.idx == reg_env_shape;
    end
  end

  ////////////////////////////////////////////////////////////
  // field unpacking, unused bits dropped
  ////////////////////////////////////////////////////////////

  assign regs.tone_a    = {mem[reg_tone_a_hi][hi_w-1:0], mem[reg_tone_a_lo]};
  assign regs.tone_b    = {mem[reg_tone_b_hi][hi_w-1:0], mem[reg_tone_b_lo]};
  assign regs.tone_c    = {mem[reg_tone_c_hi][hi_w-1:0], mem[reg_tone_c_lo]};
  assign regs.noise_per = mem[reg_noise_per][noise_w-1:0];
  assign regs.tone_dis  = mem[reg_mixer][2:0];  // io enable bits 7:6 unused
  assign regs.noise_dis = mem[reg_mixer][5:3];
  assign regs.amp_a     = mem[reg_amp_a][level_w:0];
  assign regs.amp_b     = mem[reg_amp_b][level_w:0];
  assign regs.amp_c     = mem[reg_amp_c][level_w:0];
  assign regs.env_per   = {mem[reg_env_hi], mem[reg_env_lo]};
  assign regs.env_shape = mem[reg_env_shape][3:0];

endmodule

// ==== verilog/psg_wave_gen.sv ====
// psg wave generator
// free-running prescaler for tone and envelope ticks, three square-wave
// tone dividers and the 17-bit noise lfsr

`timescale 1ns/100ps

module psg_wave_gen (
  input  logic                     clk,
  input  logic                     reset_n,
  input  psg_synth_pkg::psg_regs_t regs,
  output logic [2:0]               tone,
  output logic                     noise,
  output logic                     env_tick
);

  import psg_synth_pkg::*;

  localparam int pre_w     = $clog2(tone_tick_div);
  localparam int env_pre_w = $clog2(env_tick_div);

  logic [pre_w-1:0]   pre;        // prescaler
  logic               tone_tick;  // one clk every tone_tick_div
  logic [tone_w-1:0]  tone_per [3];
  logic [noise_w-1:0] noise_cnt;
  logic [16:0]        lfsr;

  ////////////////////////////////////////////////////////////
  // prescaler, runs from reset regardless of registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pre <= '0;
    end else begin
      pre <= pre + 1'b1;
    end
  end

  assign tone_tick = pre == pre_w'(tone_tick_div - 1);
  assign env_tick  = pre[env_pre_w-1:0] == env_pre_w'(env_tick_div - 1);  // twice per tone tick

  ////////////////////////////////////////////////////////////
  // tone dividers
  ////////////////////////////////////////////////////////////

  assign tone_per[0] = regs.tone_a;
  assign tone_per[1] = regs.tone_b;
  assign tone_per[2] = regs.tone_c;

  for (genvar ch = 0; ch < 3; ch++) begin : g_tone
    logic [tone_w-1:0] cnt;
    logic              sq;   // square wave

    always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
        cnt <= '0;
        sq  <= 1'b0;
      end else if (tone_per[ch] == '0) begin
        cnt <= '0;  // period 0 parks low
        sq  <= 1'b0;
      end else if (tone_tick) begin
        if (cnt >= tone_per[ch]) begin
          cnt <= '0;
          sq  <= ~sq;  // half period done
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end

    assign tone[ch] = sq;
  end

  ////////////////////////////////////////////////////////////
  // noise divider and lfsr
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      noise_cnt <= '0;
      lfsr      <= '0;
    end else if (regs.noise_per == '0) begin
      noise_cnt <= '0;  // lfsr frozen
    end else if (tone_tick) begin
      if (noise_cnt >= regs.noise_per) begin
        noise_cnt <= '0;
        // all-zero state kicked out by the injected 1
        lfsr <= {lfsr[0] ^ lfsr[2] ^ (lfsr == '0), lfsr[16:1]};
      end else begin
        noise_cnt <= noise_cnt + 1'b1;
      end
    end
  end

  assign noise = lfsr[16];

endmodule

// ==== verilog/psg_envelope.sv ====
// psg envelope generator
// period divider on env ticks plus the shape fsm that walks the 4-bit gain

`timescale 1ns/100ps

module psg_envelope (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic                              env_tick,
  input  logic [psg_synth_pkg::env_w-1:0]   env_period,
  input  logic [3:0]                        shape,
  input  logic                              env_restart,
  output logic [psg_synth_pkg::level_w-1:0] gain
);

  import psg_synth_pkg::*;

  env_phase_e       phase;
  logic             dir;     // 1 counts up
  logic [env_w-1:0] cnt;     // env ticks since last step
  logic             step;    // gain moves this clk
  logic             at_end;  // gain at the far end of the ramp

  ////////////////////////////////////////////////////////////
  // period divider
  ////////////////////////////////////////////////////////////

  assign step = env_tick && env_period != '0 && cnt >= env_period;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      cnt <= '0;
    end else if (env_restart || env_period == '0) begin
      cnt <= '0;  // full period before the first step
    end else if (env_tick) begin
      if (step) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // shape fsm
  ////////////////////////////////////////////////////////////

  assign at_end = dir ? (gain == '1) : (gain == '0);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      phase <= env_idle;
      dir   <= 1'b0;
      gain  <= '1;
    end else if (env_restart) begin
      phase <= env_ramp;
      dir   <= shape[env_att_bit];
      gain  <= shape[env_att_bit] ? '0 : '1;  // attack starts low
    end else if (step && phase == env_ramp) begin
      if (!at_end) begin
        gain <= dir ? gain + 1'b1 : gain - 1'b1;
      end else if (!shape[env_cont_bit]) begin
        phase <= env_hold;  // one-shot, silent after
        gain  <= '0;
      end else if (shape[env_hold_bit]) begin
        phase <= env_hold;
        gain  <= shape[env_alt_bit] ? ~gain : gain;
      end else if (shape[env_alt_bit]) begin
        dir <= ~dir;  // end value lasts two steps, as on the chip
      end else begin
        gain <= dir ? gain + 1'b1 : gain - 1'b1;  // wraps, sawtooth
      end
    end
  end

endmodule

// ==== verilog/psg_mixer.sv ====
// psg mixer
// tone and noise gating per channel, fixed or envelope amplitude,
// registered channel levels

`timescale 1ns/100ps

module psg_mixer (
  input  logic                              clk,
  input  logic                              reset_n,
  input  psg_synth_pkg::psg_regs_t          regs,
  input  logic [2:0]                        tone,
  input  logic                              noise,
  input  logic [psg_synth_pkg::level_w-1:0] gain,
  output psg_synth_pkg::levels_t            levels
);

  import psg_synth_pkg::*;

  logic [2:0] gate;  // channel sounding this clk

  // a disabled source reads as 1, so it never blocks the other
  assign gate = (tone | regs.tone_dis) & ({3{noise}} | regs.noise_dis);

  function automatic logic [level_w-1:0] chan_level(
    input logic               on,
    input logic [level_w:0]   amp,
    input logic [level_w-1:0] env_gain
  );
    logic [level_w-1:0] lvl;
    lvl = amp[level_w] ? env_gain : amp[level_w-1:0];  // msb picks envelope
    return on ? lvl : '0;
  endfunction

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      levels <= '0;
    end else begin
      levels.a <= chan_level(gate[0], regs.amp_a, gain);
      levels.b <= chan_level(gate[1], regs.amp_b, gain);
      levels.c <= chan_level(gate[2], regs.amp_c, gain);
    end
  end

endmodule

// ==== verilog/psg_top.sv ====
// psg top level
// ay-3-8910 compatible sound generator behind the capcom bus map

`timescale 1ns/100ps

module psg_top (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic [7:0]             din,
  input  logic                   adr,
  input  logic                   wr_n,
  input  logic                   cs_n,
  output psg_synth_pkg::levels_t levels
);

  import psg_bus_pkg::*;
  import psg_synth_pkg::*;

  reg_wr_t            reg_wr;       // decoder to register file
  psg_regs_t          regs;         // decoded fields
  logic               env_restart;
  logic [2:0]         tone;
  logic               noise;
  logic               env_tick;
  logic [level_w-1:0] gain;         // envelope level

  ////////////////////////////////////////////////////////////
  // input side
  ////////////////////////////////////////////////////////////

  psg_bus_if bus_if_i (
    .clk     (clk),
    .reset_n (reset_n),
    .din     (din),
    .adr     (adr),
    .wr_n    (wr_n),
    .cs_n    (cs_n),
    .reg_wr  (reg_wr)
  );

  psg_reg_file reg_file_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .reg_wr      (reg_wr),
    .regs        (regs),
    .env_restart (env_restart)
  );

  ////////////////////////////////////////////////////////////
  // generators
  ////////////////////////////////////////////////////////////

  psg_wave_gen wave_gen_i (
    .clk      (clk),
    .reset_n  (reset_n),
    .regs     (regs),
    .tone     (tone),
    .noise    (noise),
    .env_tick (env_tick)
  );

  psg_envelope envelope_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .env_tick    (env_tick),
    .env_period  (regs.env_per),
    .shape       (regs.env_shape),
    .env_restart (env_restart),
    .gain        (gain)
  );

  ////////////////////////////////////////////////////////////
  // output side
  ////////////////////////////////////////////////////////////

  psg_mixer mixer_i (
    .clk     (clk),
    .reset_n (reset_n),
    .regs    (regs),
    .tone    (tone),
    .noise   (noise),
    .gain    (gain),
    .levels  (levels)
  );

endmodule

// ==== dv/tb_psg.sv ====
// psg testbench
// table-driven register writes over the capcom bus, checks on the channel
// levels for fixed amplitude, tone period, envelope shapes and noise

`timescale 1ns/100ps

module tb_psg;

  import psg_synth_pkg::*;

  typedef enum logic [1:0] {
    chk_steady,  // whole levels word after the writes
    chk_half,    // high and low spans of one channel
    chk_env,     // envelope value sequence on one channel
    chk_set      // channel only shows 0 or the expected level
  } chk_kind_e;

  localparam int n_rows    = 10;
  localparam int max_wr    = 5;
  localparam int n_spans   = 4;     // tone spans measured
  localparam int noise_win = 2000;  // cycles watched for noise

  typedef struct packed {
    logic [2:0]              n_wr;      // write slots in use
    logic [max_wr-1:0][11:0] wr;        // {index, data}, slot 0 first
    logic                    cs_off;    // data cycles with cs_n high
    chk_kind_e               kind;
    logic [1:0]              chan;      // 0 a, 1 b, 2 c
    logic [15:0]             expected;  // meaning depends on kind
  } row_t;

  logic        clk;
  logic        reset_n;
  logic [7:0]  din;
  logic        adr;
  logic        wr_n;
  logic        cs_n;
  levels_t     levels;

  row_t        rows [n_rows];
  string       test_name [n_rows];
  int          n_used = 0;
  logic [31:0] rng = 32'ha92c_61ce;
  logic [11:0] last_levels = '0;  // last steady levels word
  int          cycles = 0;
  int          limit = 0;         // 0 until the table is built

  psg_top dut_i (
    .clk     (clk),
    .reset_n (reset_n),
    .din     (din),
    .adr     (adr),
    .wr_n    (wr_n),
    .cs_n    (cs_n),
    .levels  (levels)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 100 MHz
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
      abort_run($sformatf("timeout, no result after %0d cycles", cycles));
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [3:0] chan_of(input levels_t l, input logic [1:0] ch);
    case (ch)
      2'd0:    return l.a;
      2'd1:    return l.b;
      2'd2:    return l.c;
      default: return 4'h0;
    endcase
  endfunction

  // k-th distinct envelope value, decay or attack triangle
  function automatic int env_value(input logic [3:0] shape, input int k);
    if (!shape[2]) begin
      return (k <= 15) ? 15 - k : 0;  // one-shot decay, then silent
    end
    if (k <= 15) begin
      return k;
    end
    if (k <= 30) begin
      return 30 - k;
    end
    return k - 30;
  endfunction

  // steps a value is held; triangle ends sit while the direction turns
  function automatic int env_steps(input logic [3:0] shape, input int k);
    if (shape[2] && shape[1] && (k == 15 || k == 30)) begin
      return 2;
    end
    return 1;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_eq(input string name, input int expected, input int actual);
    if (expected != actual) begin
      abort_run($sformatf("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual));
    end
  endtask

  task automatic new_row(input string name, input chk_kind_e kind, input logic [1:0] chan,
                         input logic [15:0] expected);
    rows[n_used] = '0;
    rows[n_used].kind = kind;
    rows[n_used].chan = chan;
    rows[n_used].expected = expected;
    test_name[n_used] = name;
    n_used++;
  endtask

  task automatic add_wr(input logic [3:0] idx, input logic [7:0] data);
    rows[n_used-1].wr[rows[n_used-1].n_wr] = {idx, data};
    rows[n_used-1].n_wr = rows[n_used-1].n_wr + 3'd1;
  endtask

  // select cycle then data cycle, strobes dropped afterwards
  task automatic bus_write(input logic [3:0] idx, input logic [7:0] data, input logic cs_off);
    @(negedge clk);
    cs_n = 1'b0;
    wr_n = 1'b0;
    adr  = 1'b0;
    din  = {4'h0, idx};
    @(negedge clk);
    cs_n = cs_off;  // high here means the data cycle is ignored
    adr  = 1'b1;
    din  = data;
    @(negedge clk);
    cs_n = 1'b1;
    wr_n = 1'b1;
    adr  = 1'b0;
    din  = 8'h00;
  endtask

  // cycles until the channel leaves a value
  task automatic wait_change(input string name, input logic [1:0] ch, input logic [3:0] from,
                             input int bound, output int span);
    span = 0;
    while (chan_of(levels, ch) == from) begin
      @(negedge clk);
      span++;
      if (span > bound) begin
        abort_run($sformatf("%s: channel %0d stuck at %0d", name, ch, from));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // checks per row kind
  ////////////////////////////////////////////////////////////

  task automatic check_steady(input string name, input row_t row);
    if (row.n_wr != 3'd0) begin
      @(negedge clk);
      check_eq({name, " (too early)"}, int'(last_levels), int'(levels));  // pipeline not through
      repeat (2) @(negedge clk);
    end
    check_eq(name, int'(row.expected), int'(levels));
    last_levels = row.expected[11:0];
  endtask

  task automatic check_half(input string name, input row_t row);
    logic [3:0] cur;
    int         span;
    repeat (3) @(negedge clk);
    cur = chan_of(levels, row.chan);
    wait_change(name, row.chan, cur, 2 * int'(row.expected), span);  // first edge, partial
    for (int i = 0; i < n_spans; i++) begin
      cur = chan_of(levels, row.chan);
      wait_change(name, row.chan, cur, 2 * int'(row.expected), span);
      check_eq(name, int'(row.expected), span);
    end
  endtask

  task automatic check_env(input string name, input row_t row);
    logic [3:0] shape;
    logic [3:0] cur;
    int         span;
    int         step;
    int         n_seg;
    shape = row.wr[row.n_wr - 3'd1][3:0];  // shape write comes last
    step  = int'(row.expected);
    n_seg = shape[2] ? 32 : 16;
    repeat (3) @(negedge clk);  // restart reaches the output
    cur = chan_of(levels, row.chan);
    check_eq(name, env_value(shape, 0), int'(cur));
    for (int k = 1; k < n_seg; k++) begin
      wait_change(name, row.chan, cur, 3 * step, span);
      if (k > 1) begin
        check_eq(name, env_steps(shape, k - 1) * step, span);  // first value partial
      end
      cur = chan_of(levels, row.chan);
      check_eq(name, env_value(shape, k), int'(cur));
    end
    if (!shape[3]) begin
      repeat (4 * step) begin
        @(negedge clk);
        check_eq(name, 0, int'(chan_of(levels, row.chan)));  // stays silent
      end
    end
  endtask

  task automatic check_set(input string name, input row_t row);
    logic [3:0] cur;
    logic [3:0] prev_v;
    int         changes;
    changes = 0;
    repeat (3) @(negedge clk);
    prev_v = chan_of(levels, row.chan);
    for (int i = 0; i < noise_win; i++) begin
      @(negedge clk);
      cur = chan_of(levels, row.chan);
      if (cur != 4'd0 && cur != row.expected[3:0]) begin
        check_eq(name, int'(row.expected), int'(cur));
      end
      if (cur != prev_v) begin
        changes++;
      end
      prev_v = cur;
    end
    if (changes == 0) begin
      abort_run($sformatf("%s: channel %0d never changed", name, row.chan));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////

  task automatic build_rows();
    logic [3:0] amp_a;
    logic [3:0] amp_b;
    logic [3:0] amp_c;
    logic [7:0] tone_p;
    rng    = xorshift(rng);
    amp_a  = rng[3:0];
    rng    = xorshift(rng);
    amp_b  = rng[3:0];
    rng    = xorshift(rng);
    amp_c  = rng[3:0];
    rng    = xorshift(rng);
    tone_p = 8'(rng % 32'd20) + 8'd1;  // 1 to 20

    new_row("reset", chk_steady, 2'd0, 16'h0000);
    new_row("mixer_off", chk_steady, 2'd0, 16'h0000);
    add_wr(reg_mixer, 8'h3f);  // all tones and noise disabled
    new_row("amp_a", chk_steady, 2'd0, {4'h0, amp_a, 8'h00});
    add_wr(reg_amp_a, {4'h0, amp_a});
    new_row("amp_b", chk_steady, 2'd1, {4'h0, amp_a, amp_b, 4'h0});
    add_wr(reg_amp_b, {4'h0, amp_b});
    new_row("amp_c", chk_steady, 2'd2, {4'h0, amp_a, amp_b, amp_c});
    add_wr(reg_amp_c, {4'h0, amp_c});
    new_row("cs_high", chk_steady, 2'd0, {4'h0, amp_a, amp_b, amp_c});
    add_wr(reg_amp_a, {4'h0, ~amp_a});
    rows[n_used-1].cs_off = 1'b1;
    // half period in clk is (P+1) tone ticks of 16 clk
    new_row("tone_a", chk_half, 2'd0, 16'((int'(tone_p) + 1) * 16));
    add_wr(reg_tone_a_lo, tone_p);
    add_wr(reg_tone_a_hi, 8'h00);
    add_wr(reg_amp_a, 8'h0f);
    add_wr(reg_mixer, 8'h3e);  // tone a only
    // step every (E+1) env ticks of 8 clk
    new_row("env_decay", chk_env, 2'd0, 16'd16);
    add_wr(reg_mixer, 8'h3f);
    add_wr(reg_amp_a, 8'h10);  // envelope drives a
    add_wr(reg_env_lo, 8'h01);
    add_wr(reg_env_hi, 8'h00);
    add_wr(reg_env_shape, 8'h00);
    new_row("env_triangle", chk_env, 2'd0, 16'd16);
    add_wr(reg_env_shape, 8'h0e);
    new_row("noise_b", chk_set, 2'd1, 16'd9);
    add_wr(reg_mixer, 8'h2f);  // noise on b only
    add_wr(reg_amp_b, 8'h09);
    add_wr(reg_noise_per, 8'h01);
  endtask

  // longest wait per row, summed and doubled
  function automatic int run_limit();
    int sum;
    sum = 8;
    for (int r = 0; r < n_used; r++) begin
      sum += 3 * int'(rows[r].n_wr) + 3;
      case (rows[r].kind)
        chk_half: sum += (n_spans + 2) * int'(rows[r].expected);
        chk_env:  sum += 40 * int'(rows[r].expected);
        chk_set:  sum += noise_win;
        default:  sum += 0;
      endcase
    end
    return 2 * sum;
  endfunction

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    reset_n = 1'b0;
    din     = 8'h00;
    adr     = 1'b0;
    wr_n    = 1'b1;
    cs_n    = 1'b1;
    build_rows();
    limit = run_limit();
    repeat (8) @(negedge clk);
    reset_n = 1'b1;
    for (int r = 0; r < n_used; r++) begin
      for (int i = 0; i < int'(rows[r].n_wr); i++) begin
        bus_write(rows[r].wr[i][11:8], rows[r].wr[i][7:0], rows[r].cs_off);
      end
      case (rows[r].kind)
        chk_steady: check_steady(test_name[r], rows[r]);
        chk_half:   check_half(test_name[r], rows[r]);
        chk_env:    check_env(test_name[r], rows[r]);
        default:    check_set(test_name[r], rows[r]);
      endcase
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== sim.f ====
verilog/psg_bus_pkg.sv
verilog/psg_synth_pkg.sv
verilog/psg_bus_if.sv
verilog/psg_reg_file.sv
verilog/psg_wave_gen.sv
verilog/psg_envelope.sv
verilog/psg_mixer.sv
verilog/psg_top.sv
dv/tb_psg.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the psg testbench with verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f sim.f --top-module tb_psg -o tb_psg_sim
status=0
out=$(./obj_dir/tb_psg_sim 2>&1) || status=$?
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q "^Simulation finished: PASS$"; then
  exit 0
fi
echo "simulation did not pass, exit status $status"
exit 1
